// ==== hw/ooo_pkg.sv ====
package ooo_pkg;

    localparam int NUM_REGS  = 32;
    localparam int NUM_SLOTS = 4;

    localparam int DATA_W    = 32;
    localparam int REG_IDX_W = 5;
    localparam int TAG_W     = 3;
    localparam int ADDR_W    = 32;
    localparam int IMM_W     = 12;

    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;   // x0 reads as zero
    typedef logic [TAG_W-1:0]     tag_t;       // 0 = no pending writer
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [IMM_W-1:0]     imm_t;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_addi                                // rs1 + sext(imm)
    } alu_op_e;

    typedef struct packed {
        alu_op_e  op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        imm_t     imm;
        addr_t    pc;
    } instr_t;

    typedef struct packed {
        data_t value;
        tag_t  tag;                            // value valid when tag is 0
    } operand_t;

    typedef struct packed {
        instr_t   instr;
        operand_t src1;
        operand_t src2;
    } slot_entry_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t data;
    } cdb_t;

    typedef struct packed {
        reg_idx_t rd;
        data_t    data;
        addr_t    pc;
    } result_t;

endpackage

// ==== hw/reg_rename_file.sv ====
module reg_rename_file
    import ooo_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    output operand_t rs1_opnd,
    output operand_t rs2_opnd,

    input  logic     rename_en,
    input  reg_idx_t rename_rd,
    input  tag_t     rename_tag,

    input  cdb_t     cdb,
    input  reg_idx_t cdb_rd
);

    data_t regs [NUM_REGS];
    tag_t  tags [NUM_REGS];

    logic  wb_hit;
    logic  rename_hit;

    // a pending register whose writer is on the bus right now reads as valid
    function automatic operand_t read_opnd(reg_idx_t idx);
        operand_t opnd;
        opnd.value = regs[idx];
        opnd.tag   = tags[idx];
        if (cdb.valid && opnd.tag == cdb.tag) begin
            opnd.value = cdb.data;
            opnd.tag   = '0;
        end
        return opnd;
    endfunction

    always_comb begin
        rs1_opnd = read_opnd(rs1_idx);
        rs2_opnd = read_opnd(rs2_idx);
    end

    // only the latest writer of a register may update it
    assign wb_hit     = cdb.valid && (cdb_rd != '0) && (tags[cdb_rd] == cdb.tag);
    assign rename_hit = rename_en && (rename_rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            if (wb_hit) begin
                regs[cdb_rd] <= cdb.data;
                tags[cdb_rd] <= '0;
            end
            if (rename_hit) begin
                tags[rename_rd] <= rename_tag;  // later assignment, new tag wins
            end
        end
    end

endmodule

// ==== hw/dispatch_ctrl.sv ====
module dispatch_ctrl
    import ooo_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 in_req,
    input  instr_t               in_instr,
    output logic                 in_ack,

    output reg_idx_t             rs1_idx,
    output reg_idx_t             rs2_idx,
    input  operand_t             rs1_opnd,
    input  operand_t             rs2_opnd,

    output logic                 rename_en,
    output reg_idx_t             rename_rd,
    output tag_t                 rename_tag,

    input  logic [NUM_SLOTS-1:0] slot_busy,
    output logic [NUM_SLOTS-1:0] slot_wr,
    output slot_entry_t          slot_entry
);

    typedef enum logic [1:0] {
        idle,
        ack_hi,
        wait_req_lo
    } disp_state_e;

    disp_state_e          state;
    disp_state_e          state_nxt;
    logic [NUM_SLOTS-1:0] free_oh;
    tag_t                 free_tag;
    logic                 accept;

    // lowest free slot, tag = index + 1
    always_comb begin
        free_oh  = '0;
        free_tag = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (!slot_busy[i]) begin
                free_oh    = '0;
                free_oh[i] = 1'b1;
                free_tag   = tag_t'(i + 1);
            end
        end
    end

    assign accept = (state == idle) && in_req && (free_tag != '0);

    assign rs1_idx = in_instr.rs1;
    assign rs2_idx = in_instr.rs2;

    always_comb begin
        slot_entry.instr = in_instr;
        slot_entry.src1  = rs1_opnd;
        if (in_instr.op == op_addi) begin
            slot_entry.src2.value = data_t'(in_instr.imm);  // raw imm, alu sign-extends
            slot_entry.src2.tag   = '0;
        end else begin
            slot_entry.src2 = rs2_opnd;
        end
    end

    assign slot_wr    = accept ? free_oh : '0;
    assign rename_en  = accept;
    assign rename_rd  = in_instr.rd;
    assign rename_tag = free_tag;

    always_comb begin
        state_nxt = state;
        case (state)
            idle:        if (accept) state_nxt = ack_hi;
            ack_hi:      state_nxt = in_req ? wait_req_lo : idle;
            wait_req_lo: if (!in_req) state_nxt = idle;
            default:     state_nxt = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= state_nxt;
        end
    end

    assign in_ack = (state != idle);

endmodule

// ==== hw/rs_slot.sv ====
module rs_slot
    import ooo_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        wr,
    input  slot_entry_t entry_in,

    input  cdb_t        cdb,
    input  logic        release_en,

    output logic        busy,
    output logic        ready,
    output slot_entry_t entry
);

    logic src1_hit;
    logic src2_hit;

    // snoop the bus for operands still waiting on a tag
    assign src1_hit = busy && cdb.valid && (entry.src1.tag == cdb.tag);
    assign src2_hit = busy && cdb.valid && (entry.src2.tag == cdb.tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (wr) begin
            busy <= 1'b1;
        end else if (release_en) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            entry <= entry_in;
        end else begin
            if (src1_hit) begin
                entry.src1.value <= cdb.data;
                entry.src1.tag   <= '0;
            end
            if (src2_hit) begin
                entry.src2.value <= cdb.data;
                entry.src2.tag   <= '0;
            end
        end
    end

    assign ready = busy && (entry.src1.tag == '0) && (entry.src2.tag == '0);

endmodule

// ==== hw/wb_arbiter.sv ====
module wb_arbiter
    import ooo_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    input  logic [NUM_SLOTS-1:0] slot_ready,
    input  slot_entry_t          slot_entries [NUM_SLOTS],
    output logic [NUM_SLOTS-1:0] release_vec,

    output cdb_t                 cdb,
    output reg_idx_t             cdb_rd,

    output logic                 out_req,
    output result_t              out_result,
    input  logic                 out_ack
);

    typedef enum logic [1:0] {
        pick,
        req_hi,
        wait_ack_lo
    } arb_state_e;

    arb_state_e  state;
    slot_entry_t pick_entry;
    tag_t        pick_tag;
    tag_t        held_tag;
    data_t       alu_out;
    logic        bcast;

    function automatic data_t alu(alu_op_e op, data_t a, data_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_addi: return a + {{(DATA_W-IMM_W){b[IMM_W-1]}}, b[IMM_W-1:0]};
            default: return '0;
        endcase
    endfunction

    // lowest ready slot wins
    always_comb begin
        pick_entry = slot_entries[0];
        pick_tag   = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (slot_ready[i]) begin
                pick_entry = slot_entries[i];
                pick_tag   = tag_t'(i + 1);
            end
        end
    end

    assign alu_out = alu(pick_entry.instr.op, pick_entry.src1.value, pick_entry.src2.value);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= pick;
        end else begin
            case (state)
                pick:        if (|slot_ready) state <= req_hi;
                req_hi:      if (out_ack) state <= wait_ack_lo;
                wait_ack_lo: if (!out_ack) state <= pick;
                default:     state <= pick;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == pick && |slot_ready) begin
            held_tag        <= pick_tag;
            out_result.rd   <= pick_entry.instr.rd;
            out_result.data <= alu_out;
            out_result.pc   <= pick_entry.instr.pc;
        end
    end

    assign out_req = (state == req_hi);
    assign bcast   = (state == req_hi) && out_ack;  // one cycle, first ack-high edge

    always_comb begin
        cdb.valid = bcast;
        cdb.tag   = held_tag;
        cdb.data  = out_result.data;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            release_vec[i] = bcast && (held_tag == tag_t'(i + 1));
        end
    end

    assign cdb_rd = out_result.rd;

endmodule

// ==== hw/ooo_core_top.sv ====
module ooo_core_top
    import ooo_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    input  logic    in_req,
    input  instr_t  in_instr,
    output logic    in_ack,

    output logic    out_req,
    output result_t out_result,
    input  logic    out_ack
);

    reg_idx_t             rs1_idx;
    reg_idx_t             rs2_idx;
    operand_t             rs1_opnd;
    operand_t             rs2_opnd;
    logic                 rename_en;
    reg_idx_t             rename_rd;
    tag_t                 rename_tag;

    logic [NUM_SLOTS-1:0] slot_busy;
    logic [NUM_SLOTS-1:0] slot_ready;
    logic [NUM_SLOTS-1:0] slot_wr;
    logic [NUM_SLOTS-1:0] release_vec;
    slot_entry_t          slot_entry;
    slot_entry_t          slot_entries [NUM_SLOTS];

    cdb_t                 cdb;
    reg_idx_t             cdb_rd;

    dispatch_ctrl u_dispatch (
        .clk        (clk),
        .rst        (rst),
        .in_req     (in_req),
        .in_instr   (in_instr),
        .in_ack     (in_ack),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .rs1_opnd   (rs1_opnd),
        .rs2_opnd   (rs2_opnd),
        .rename_en  (rename_en),
        .rename_rd  (rename_rd),
        .rename_tag (rename_tag),
        .slot_busy  (slot_busy),
        .slot_wr    (slot_wr),
        .slot_entry (slot_entry)
    );

    reg_rename_file u_regfile (
        .clk        (clk),
        .rst        (rst),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .rs1_opnd   (rs1_opnd),
        .rs2_opnd   (rs2_opnd),
        .rename_en  (rename_en),
        .rename_rd  (rename_rd),
        .rename_tag (rename_tag),
        .cdb        (cdb),
        .cdb_rd     (cdb_rd)
    );

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : gen_slot
        rs_slot u_slot (
            .clk        (clk),
            .rst        (rst),
            .wr         (slot_wr[i]),
            .entry_in   (slot_entry),
            .cdb        (cdb),
            .release_en (release_vec[i]),
            .busy       (slot_busy[i]),
            .ready      (slot_ready[i]),
            .entry      (slot_entries[i])
        );
    end

    wb_arbiter u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .slot_ready   (slot_ready),
        .slot_entries (slot_entries),
        .release_vec  (release_vec),
        .cdb          (cdb),
        .cdb_rd       (cdb_rd),
        .out_req      (out_req),
        .out_result   (out_result),
        .out_ack      (out_ack)
    );

endmodule

// ==== dv/ooo_chk.sv ====
module ooo_chk
    import ooo_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    in_req,
    input logic    in_ack,
    input logic    out_req,
    input logic    out_ack,
    input result_t out_result
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(in_ack) |-> $past(in_req))
        else begin
            fail_count++;
            $error("in_ack rose while in_req was low");
        end

    in_req_held: assert property (@(posedge clk) disable iff (rst)
        $fell(in_req) |-> in_ack)
        else begin
            fail_count++;
            $error("in_req dropped before in_ack was given");
        end

    out_req_held: assert property (@(posedge clk) disable iff (rst)
        out_req && !out_ack |=> out_req)
        else begin
            fail_count++;
            $error("out_req dropped before out_ack was given");
        end

    result_stable: assert property (@(posedge clk) disable iff (rst)
        out_req && !out_ack |=> $stable(out_result))
        else begin
            fail_count++;
            $error("out_result changed while waiting for out_ack");
        end

endmodule

bind ooo_core_top ooo_chk u_chk (.*);

// ==== dv/ooo_checker.sv ====
module ooo_checker
    import ooo_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    in_ack,
    input  instr_t  in_instr,
    input  logic    out_req,
    input  logic    out_ack,
    input  result_t out_result,
    input  logic    tbl_valid,      // in_instr comes with a table value
    input  data_t   tbl_data,
    input  logic    done,
    input  int      assert_fails,
    output int      err_count,
    output int      acc_count,
    output int      res_count
);
    timeunit 1ns;
    timeprecision 100ps;

    data_t    ref_regs [NUM_REGS];  // in-order register model
    data_t    exp_data [addr_t];    // outstanding results, keyed by pc
    reg_idx_t exp_rd [addr_t];
    data_t    tbl_exp [addr_t];
    data_t    r;
    logic     ack_q;
    logic     reported;

    function automatic data_t model_result(instr_t ins);
        data_t a;
        data_t b;
        a = ref_regs[ins.rs1];
        b = ref_regs[ins.rs2];
        if (ins.op == op_addi) begin
            b = {{(DATA_W-IMM_W){ins.imm[IMM_W-1]}}, ins.imm};
        end
        case (ins.op)
            op_add, op_addi: return a + b;
            op_sub:          return a - b;
            op_and:          return a & b;
            op_or:           return a | b;
            op_xor:          return a ^ b;
            default:         return '0;
        endcase
    endfunction

    task automatic check_result();
        addr_t pc;
        pc = out_result.pc;
        res_count++;
        if (!exp_data.exists(pc)) begin
            err_count++;
            $display("%0t: pc %h reported but never accepted, or reported twice", $time, pc);
        end else begin
            if (out_result.rd !== exp_rd[pc] || out_result.data !== exp_data[pc]) begin
                err_count++;
                $display("MISMATCH %0t: pc %h gave x%0d=%h, expected x%0d=%h", $time, pc,
                         out_result.rd, out_result.data, exp_rd[pc], exp_data[pc]);
            end
            if (tbl_exp.exists(pc) && out_result.data !== tbl_exp[pc]) begin
                err_count++;
                $display("MISMATCH %0t: pc %h gave %h, table says %h", $time, pc,
                         out_result.data, tbl_exp[pc]);
            end
            exp_data.delete(pc);
            exp_rd.delete(pc);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            foreach (ref_regs[i])
                ref_regs[i] = '0;
            ack_q    = 1'b0;
            reported = 1'b0;
        end else begin
            if (in_ack && !ack_q) begin  // first cycle of in_ack, instr still held
                r = model_result(in_instr);
                if (in_instr.rd != '0)
                    ref_regs[in_instr.rd] = r;
                exp_data[in_instr.pc] = r;
                exp_rd[in_instr.pc]   = in_instr.rd;
                if (tbl_valid)
                    tbl_exp[in_instr.pc] = tbl_data;
                acc_count++;
            end
            ack_q = in_ack;
            if (out_req && out_ack)
                check_result();
            if (acc_count - res_count > NUM_SLOTS) begin
                err_count++;
                $display("%0t: %0d instructions in flight with only %0d slots", $time,
                         acc_count - res_count, NUM_SLOTS);
            end
            if (done && !reported) begin
                reported = 1'b1;
                if (acc_count != res_count || exp_data.num() != 0) begin
                    err_count++;
                    $display("%0t: %0d accepted but %0d reported, %0d pcs never seen", $time,
                             acc_count, res_count, exp_data.num());
                end
                $display("checker: %0d accepted, %0d results, %0d errors, %0d assertion failures",
                         acc_count, res_count, err_count, assert_fails);
            end
        end
    end

endmodule

// ==== dv/ooo_tb.sv ====
module ooo_tb
    import ooo_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          NUM_DIR     = 21;
    localparam int          NUM_RAND    = 200;
    localparam int          TOTAL_INSTR = NUM_DIR + NUM_RAND;
    localparam logic [31:0] SEED        = 32'hdca4_ad98;

    logic        clk;
    logic        rst;
    logic        in_req;
    logic        in_ack;
    logic        out_req;
    logic        out_ack;
    instr_t      in_instr;
    result_t     out_result;
    logic        tbl_valid;
    data_t       tbl_data;
    logic        hold_ack;      // withholds out_ack while set
    logic        done;
    int          err_count;
    int          acc_count;
    int          res_count;
    int          ack_delay;
    logic [31:0] stim_seed;
    logic [31:0] resp_seed;
    instr_t      dir_instr [$];
    data_t       dir_exp [$];
    instr_t      ins;

    ooo_core_top DUT (.clk, .rst, .in_req, .in_instr, .in_ack,
                      .out_req, .out_result, .out_ack);

    ooo_checker u_checker (.*, .assert_fails(DUT.u_chk.fail_count));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic void add_entry(alu_op_e op, int rd, int rs1, int rs2, int imm,
                                      data_t exp);
        instr_t e;
        e.op  = op;
        e.rd  = reg_idx_t'(rd);
        e.rs1 = reg_idx_t'(rs1);
        e.rs2 = reg_idx_t'(rs2);
        e.imm = imm_t'(imm);
        e.pc  = '0;
        dir_instr.push_back(e);
        dir_exp.push_back(exp);
    endfunction

    // registers limited to x0..x7 so dependencies are frequent
    function automatic instr_t make_rand_instr(int idx);
        instr_t e;
        stim_seed = lcg_step(stim_seed);
        e.op  = alu_op_e'(3'(stim_seed[31:16] % 6));
        e.rd  = reg_idx_t'(stim_seed[30:28]);
        e.rs1 = reg_idx_t'(stim_seed[27:25]);
        e.rs2 = reg_idx_t'(stim_seed[24:22]);
        stim_seed = lcg_step(stim_seed);
        e.imm = stim_seed[27:16];
        e.pc  = addr_t'(32'h1000 + 4 * idx);
        return e;
    endfunction

    // called 1 ns after a rising edge, returns 1 ns after the edge where in_ack is seen low
    task automatic send_instr(instr_t e, logic has_exp, data_t exp);
        in_instr  = e;
        tbl_valid = has_exp;
        tbl_data  = exp;
        in_req    = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!in_ack);
        in_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (in_ack);
    endtask

    initial begin
        out_ack   = 1'b0;
        resp_seed = SEED;
        forever begin
            @(posedge clk);
            #1;
            if (out_req && !hold_ack) begin
                resp_seed = lcg_step(resp_seed);
                ack_delay = int'(resp_seed[31:16] % 7);
                repeat (ack_delay) begin
                    @(posedge clk);
                    #1;
                end
                out_ack = 1'b1;
                do begin
                    @(posedge clk);
                    #1;
                end while (out_req);
                out_ack = 1'b0;
            end
        end
    end

    initial begin
        repeat (TOTAL_INSTR * 40) @(posedge clk);
        $display("timeout: results still missing after %0d cycles", TOTAL_INSTR * 40);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        in_req    = 1'b0;
        in_instr  = '0;
        tbl_valid = 1'b0;
        tbl_data  = '0;
        hold_ack  = 1'b0;
        done      = 1'b0;
        stim_seed = SEED;
        add_entry(op_addi,  1,  0,  0,   100, 32'd100);
        add_entry(op_addi,  2,  0,  0,    -7, 32'hffff_fff9);  // negative imm
        add_entry(op_add,   3,  1,  2,     0, 32'd93);
        add_entry(op_sub,   4,  1,  2,     0, 32'd107);
        add_entry(op_addi,  5,  0,  0, 'h0f0, 32'h0f0);
        add_entry(op_addi,  6,  0,  0, 'h03c, 32'h03c);
        add_entry(op_and,   7,  5,  6,     0, 32'h030);
        add_entry(op_or,    8,  5,  6,     0, 32'h0fc);
        add_entry(op_xor,   9,  5,  6,     0, 32'h0cc);
        add_entry(op_addi, 10, 10,  0,     1, 32'd1);          // raw chain
        add_entry(op_add,  10, 10, 10,     0, 32'd2);
        add_entry(op_add,  11, 10,  1,     0, 32'd102);
        add_entry(op_addi, 12,  0,  0,    11, 32'd11);         // x12 written twice
        add_entry(op_addi, 12,  0,  0,    22, 32'd22);
        add_entry(op_add,  13, 12,  0,     0, 32'd22);
        add_entry(op_addi,  0,  1,  0,     5, 32'd105);        // reported, x0 unchanged
        add_entry(op_add,  14,  0,  0,     0, 32'd0);
        add_entry(op_addi, 15,  0,  0,    -1, 32'hffff_ffff);
        add_entry(op_sub,  16,  0, 15,     0, 32'd1);
        add_entry(op_xor,  17, 15,  2,     0, 32'd6);
        add_entry(op_or,   18,  4,  3,     0, 32'h07f);
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        foreach (dir_instr[i]) begin
            ins    = dir_instr[i];
            ins.pc = addr_t'(32'h100 + 4 * i);
            send_instr(ins, 1'b1, dir_exp[i]);
        end
        fork
            begin
                #1 hold_ack = 1'b1;  // slots fill up and in_ack stalls
                repeat (60) @(posedge clk);
                #2 hold_ack = 1'b0;
            end
        join_none
        for (int i = 0; i < NUM_RAND; i++)
            send_instr(make_rand_instr(i), 1'b0, '0);
        wait (res_count == acc_count);
        @(posedge clk);
        #1 done = 1'b1;
        @(posedge clk);
        #1;
        if (err_count == 0 && DUT.u_chk.fail_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
hw/ooo_pkg.sv
hw/reg_rename_file.sv
hw/dispatch_ctrl.sv
hw/rs_slot.sv
hw/wb_arbiter.sv
hw/ooo_core_top.sv
dv/ooo_chk.sv
dv/ooo_checker.sv
dv/ooo_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module ooo_tb -f filelist.f -o ooo_sim

./obj_dir/ooo_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "run_sim: passed"
else
    echo "run_sim: failed, see sim.log"
    exit 1
fi
